// File: runSim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module cpuTb \
    -o cpuTbSim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/cpuTbSim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log \
    && { echo "result: FAIL"; exit 1; } \
    || { echo "result: PASS"; exit 0; }

// File: source/cpuPkg.sv
package cpuPkg;

    localparam int wordBits = 16;

    typedef logic [1:0] regAddr;

    // opcode field, bits 15..12
    localparam logic [3:0] opBne   = 4'd0;
    localparam logic [3:0] opBeq   = 4'd1;
    localparam logic [3:0] opBgz   = 4'd2;
    localparam logic [3:0] opBlz   = 4'd3;
    localparam logic [3:0] opAdi   = 4'd4;
    localparam logic [3:0] opOri   = 4'd5;
    localparam logic [3:0] opLhi   = 4'd6;
    localparam logic [3:0] opLwd   = 4'd7;
    localparam logic [3:0] opSwd   = 4'd8;
    localparam logic [3:0] opJmp   = 4'd9;
    localparam logic [3:0] opJal   = 4'd10;
    localparam logic [3:0] opRtype = 4'd15;

    // func field of R-type, bits 5..0
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnNot = 6'd4;
    localparam logic [5:0] fnShl = 6'd6;
    localparam logic [5:0] fnShr = 6'd7;
    localparam logic [5:0] fnJpr = 6'd25;
    localparam logic [5:0] fnJrl = 6'd26;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    // how execute resolves control flow
    localparam logic [2:0] brNone = 3'd0;
    localparam logic [2:0] brBne  = 3'd1;
    localparam logic [2:0] brBeq  = 3'd2;
    localparam logic [2:0] brBgz  = 3'd3;
    localparam logic [2:0] brBlz  = 3'd4;
    localparam logic [2:0] brJmp  = 3'd5; // pc page plus target field
    localparam logic [2:0] brJreg = 3'd6; // target from rs

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluShl,
        aluShr,
        aluLhi
    } aluOp;

    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            regAddr     rs;
            regAddr     rt;
            regAddr     rd;
            logic [5:0] func;
        } rType;
        struct packed {
            logic [3:0] opcode;
            regAddr     rs;
            regAddr     rt;
            logic [7:0] imm;
        } iType;
        struct packed {
            logic [3:0]  opcode;
            logic [11:0] target;
        } jType;
    } instrWord;

    // ADI r0, r0, 0 with no retire bit
    localparam instrWord nopWord = instrWord'({opAdi, 12'h000});

    localparam regAddr linkReg = 2'd2;

endpackage

// File: source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [cpuPkg::wordBits-1:0] ifPc,
    input  cpuPkg::instrWord            ifInstr,
    input  logic                        ifRetire,
    input  logic                        redirect,
    input  cpuPkg::regAddr              wbRd,
    input  logic [cpuPkg::wordBits-1:0] wbData,
    input  logic                        wbRegWrite,
    output logic                        stall,
    output logic                        haltSeen,
    output logic [cpuPkg::wordBits-1:0] exPc,
    output logic [cpuPkg::wordBits-1:0] exA,
    output logic [cpuPkg::wordBits-1:0] exB,
    output logic [cpuPkg::wordBits-1:0] exImm,
    output cpuPkg::regAddr              exRs,
    output cpuPkg::regAddr              exRt,
    output cpuPkg::regAddr              exRd,
    output cpuPkg::aluOp                exAluOp,
    output logic                        exAluSrcImm,
    output logic                        exMemRead,
    output logic                        exMemWrite,
    output logic                        exRegWrite,
    output logic                        exMemToReg,
    output logic                        exIsWwd,
    output logic                        exIsHalt,
    output logic [2:0]                  exBranchKind,
    output logic                        exRetire
);
    import cpuPkg::*;

    logic [wordBits-1:0] rsData;
    logic [wordBits-1:0] rtData;
    logic [wordBits-1:0] idImm;
    regAddr              idRd;
    aluOp                idAluOp;
    logic                idSrcImm;
    logic                idMemRead;
    logic                idMemWrite;
    logic                idRegWrite;
    logic                idMemToReg;
    logic                idIsWwd;
    logic                idIsHalt;
    logic [2:0]          idKind;
    logic                usesRs;
    logic                usesRt;
    logic                keep;
    logic                haltNow;
    logic                haltReg;

    registerFile registerFile_i (
        .clk    (clk),
        .rstN   (rstN),
        .rsAddr (ifInstr.rType.rs),
        .rtAddr (ifInstr.rType.rt),
        .wAddr  (wbRd),
        .wData  (wbData),
        .wEn    (wbRegWrite),
        .rsData (rsData),
        .rtData (rtData)
    );

    always_comb begin
        idAluOp    = aluAdd;
        idSrcImm   = 1'b1;
        idMemRead  = 1'b0;
        idMemWrite = 1'b0;
        idRegWrite = 1'b0;
        idMemToReg = 1'b0;
        idIsWwd    = 1'b0;
        idIsHalt   = 1'b0;
        idKind     = brNone;
        usesRs     = 1'b1;
        usesRt     = 1'b0;
        idRd       = ifInstr.iType.rt;
        idImm      = {{8{ifInstr.iType.imm[7]}}, ifInstr.iType.imm};
        case (ifInstr.rType.opcode)
            opAdi: idRegWrite = 1'b1;
            opOri: begin
                idAluOp    = aluOr;
                idRegWrite = 1'b1;
                idImm      = {8'h00, ifInstr.iType.imm};
            end
            opLhi: begin
                idAluOp    = aluLhi;
                idRegWrite = 1'b1;
                usesRs     = 1'b0;
                idImm      = {ifInstr.iType.imm, 8'h00};
            end
            opLwd: begin
                idMemRead  = 1'b1;
                idRegWrite = 1'b1;
                idMemToReg = 1'b1;
            end
            opSwd: begin
                idMemWrite = 1'b1;
                usesRt     = 1'b1;
            end
            opBne, opBeq: begin
                idKind = (ifInstr.rType.opcode == opBne) ? brBne : brBeq;
                usesRt = 1'b1;
            end
            opBgz: idKind = brBgz;
            opBlz: idKind = brBlz;
            opJmp, opJal: begin
                idKind     = brJmp;
                usesRs     = 1'b0;
                idImm      = {4'h0, ifInstr.jType.target};
                idRegWrite = (ifInstr.rType.opcode == opJal);
                idRd       = linkReg;
            end
            opRtype: begin
                idRd  = ifInstr.rType.rd;
                idImm = '0; // WWD passes rs through as rs + 0
                case (ifInstr.rType.func)
                    fnAdd, fnSub, fnAnd, fnOrr: begin
                        idAluOp    = (ifInstr.rType.func == fnAdd) ? aluAdd :
                                     (ifInstr.rType.func == fnSub) ? aluSub :
                                     (ifInstr.rType.func == fnAnd) ? aluAnd : aluOr;
                        idSrcImm   = 1'b0;
                        idRegWrite = 1'b1;
                        usesRt     = 1'b1;
                    end
                    fnNot, fnShl, fnShr: begin
                        idAluOp    = (ifInstr.rType.func == fnNot) ? aluNot :
                                     (ifInstr.rType.func == fnShl) ? aluShl : aluShr;
                        idRegWrite = 1'b1;
                    end
                    fnWwd: idIsWwd = 1'b1;
                    fnJpr, fnJrl: begin
                        idKind     = brJreg;
                        idRegWrite = (ifInstr.rType.func == fnJrl);
                        idRd       = linkReg;
                    end
                    fnHlt: begin
                        idIsHalt = 1'b1;
                        usesRs   = 1'b0;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // load in EX feeding a source read here
    assign stall = ifRetire && exMemRead && !redirect &&
                   ((usesRs && exRd == ifInstr.rType.rs) ||
                    (usesRt && exRd == ifInstr.rType.rt));
    assign keep = ifRetire && !stall && !redirect;

    assign haltNow  = ifRetire && idIsHalt && !redirect;
    assign haltSeen = haltReg || haltNow;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            haltReg <= 1'b0;
        end else if (haltNow) begin
            haltReg <= 1'b1;
        end
    end

    // ID/EX control, a bubble when not kept
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exAluSrcImm  <= 1'b0;
            exMemRead    <= 1'b0;
            exMemWrite   <= 1'b0;
            exRegWrite   <= 1'b0;
            exMemToReg   <= 1'b0;
            exIsWwd      <= 1'b0;
            exIsHalt     <= 1'b0;
            exBranchKind <= brNone;
            exRetire     <= 1'b0;
        end else begin
            exAluSrcImm  <= idSrcImm;
            exMemRead    <= keep && idMemRead;
            exMemWrite   <= keep && idMemWrite;
            exRegWrite   <= keep && idRegWrite;
            exMemToReg   <= keep && idMemToReg;
            exIsWwd      <= keep && idIsWwd;
            exIsHalt     <= keep && idIsHalt;
            exBranchKind <= keep ? idKind : brNone;
            exRetire     <= keep;
        end
    end

    always_ff @(posedge clk) begin
        exPc    <= ifPc;
        exA     <= rsData;
        exB     <= rtData;
        exImm   <= idImm;
        exRs    <= ifInstr.rType.rs;
        exRt    <= ifInstr.rType.rt;
        exRd    <= idRd;
        exAluOp <= idAluOp;
    end

    // a slot without retire bit arrives as the nop word
    assert property (@(posedge clk) disable iff (!rstN) !ifRetire |-> ifInstr == nopWord);

endmodule

// File: source/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [cpuPkg::wordBits-1:0] exPc,
    input  logic [cpuPkg::wordBits-1:0] exA,
    input  logic [cpuPkg::wordBits-1:0] exB,
    input  logic [cpuPkg::wordBits-1:0] exImm,
    input  cpuPkg::regAddr              exRs,
    input  cpuPkg::regAddr              exRt,
    input  cpuPkg::regAddr              exRd,
    input  cpuPkg::aluOp                exAluOp,
    input  logic                        exAluSrcImm,
    input  logic                        exMemRead,
    input  logic                        exMemWrite,
    input  logic                        exRegWrite,
    input  logic                        exMemToReg,
    input  logic                        exIsWwd,
    input  logic                        exIsHalt,
    input  logic [2:0]                  exBranchKind,
    input  logic                        exRetire,
    input  cpuPkg::regAddr              wbRd,
    input  logic                        wbRegWrite,
    input  logic [cpuPkg::wordBits-1:0] wbData,
    output logic                        redirect,
    output logic [cpuPkg::wordBits-1:0] redirectPc,
    output logic [cpuPkg::wordBits-1:0] memAddr,
    output logic [cpuPkg::wordBits-1:0] memStoreData,
    output cpuPkg::regAddr              memRd,
    output logic                        memRegWrite,
    output logic                        memMemRead,
    output logic                        memMemWrite,
    output logic                        memMemToReg,
    output logic                        memIsWwd,
    output logic                        memIsHalt,
    output logic                        memRetire,
    output logic [cpuPkg::wordBits-1:0] memResult
);
    import cpuPkg::*;

    logic [wordBits-1:0] opA;
    logic [wordBits-1:0] opB;
    logic [wordBits-1:0] aluB;
    logic [wordBits-1:0] aluResult;
    logic                taken;
    logic                isJump;

    // newest producer first
    assign opA = (memRegWrite && memRd == exRs) ? memResult :
                 (wbRegWrite && wbRd == exRs) ? wbData : exA;
    assign opB = (memRegWrite && memRd == exRt) ? memResult :
                 (wbRegWrite && wbRd == exRt) ? wbData : exB;
    assign aluB = exAluSrcImm ? exImm : opB;

    always_comb begin
        case (exAluOp)
            aluAdd:  aluResult = opA + aluB;
            aluSub:  aluResult = opA - aluB;
            aluAnd:  aluResult = opA & aluB;
            aluOr:   aluResult = opA | aluB;
            aluNot:  aluResult = ~opA;
            aluShl:  aluResult = {opA[wordBits-2:0], 1'b0};
            aluShr:  aluResult = {opA[wordBits-1], opA[wordBits-1:1]}; // keeps sign
            default: aluResult = aluB; // LHI, immediate already shifted
        endcase
    end

    always_comb begin
        case (exBranchKind)
            brBne:         taken = opA != opB;
            brBeq:         taken = opA == opB;
            brBgz:         taken = !opA[wordBits-1] && opA != '0;
            brBlz:         taken = opA[wordBits-1];
            brJmp, brJreg: taken = 1'b1;
            default:       taken = 1'b0;
        endcase
    end

    assign isJump   = exBranchKind == brJmp || exBranchKind == brJreg;
    assign redirect = exRetire && taken;

    always_comb begin
        case (exBranchKind)
            brJmp:   redirectPc = {exPc[wordBits-1:12], exImm[11:0]};
            brJreg:  redirectPc = opA;
            default: redirectPc = exPc + 1'b1 + exImm;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
            memMemToReg <= 1'b0;
            memIsWwd    <= 1'b0;
            memIsHalt   <= 1'b0;
            memRetire   <= 1'b0;
        end else begin
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
            memMemToReg <= exMemToReg;
            memIsWwd    <= exIsWwd;
            memIsHalt   <= exIsHalt;
            memRetire   <= exRetire;
        end
    end

    always_ff @(posedge clk) begin
        memAddr      <= aluResult;
        memStoreData <= opB;
        memRd        <= exRd;
        memResult    <= (isJump && exRegWrite) ? exPc + 1'b1 : aluResult; // link value
    end

    assert property (@(posedge clk) disable iff (!rstN) !(memMemRead && memMemWrite));

endmodule

// File: source/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        stall,
    input  logic                        redirect,
    input  logic [cpuPkg::wordBits-1:0] redirectPc,
    input  logic                        haltSeen,
    input  logic [cpuPkg::wordBits-1:0] instData,
    output logic [cpuPkg::wordBits-1:0] instAddress,
    output logic [cpuPkg::wordBits-1:0] ifPc,
    output cpuPkg::instrWord            ifInstr,
    output logic                        ifRetire
);
    import cpuPkg::*;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instAddress <= '0;
        end else if (redirect) begin
            instAddress <= redirectPc;
        end else if (!stall && !haltSeen) begin
            instAddress <= instAddress + 1'b1;
        end
    end

    // IF/ID
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifInstr  <= nopWord;
            ifRetire <= 1'b0;
        end else if (redirect || haltSeen) begin
            ifInstr  <= nopWord; // flushed slot
            ifRetire <= 1'b0;
        end else if (!stall) begin
            ifInstr  <= instrWord'(instData);
            ifRetire <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifPc <= instAddress;
        end
    end

    // redirect wins, decode drops its stall
    assert property (@(posedge clk) disable iff (!rstN) !(stall && redirect));

endmodule

// File: source/memWriteback.sv
`timescale 1ns/1ps

module memWriteback (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [cpuPkg::wordBits-1:0] memAddr,
    input  logic [cpuPkg::wordBits-1:0] memStoreData,
    input  cpuPkg::regAddr              memRd,
    input  logic                        memRegWrite,
    input  logic                        memMemRead,
    input  logic                        memMemWrite,
    input  logic                        memMemToReg,
    input  logic                        memIsWwd,
    input  logic                        memIsHalt,
    input  logic                        memRetire,
    input  logic [cpuPkg::wordBits-1:0] memResult,
    input  logic [cpuPkg::wordBits-1:0] readData,
    output logic [cpuPkg::wordBits-1:0] dataAddress,
    output logic                        readM,
    output logic                        writeM,
    output logic [cpuPkg::wordBits-1:0] writeData,
    output cpuPkg::regAddr              wbRd,
    output logic                        wbRegWrite,
    output logic [cpuPkg::wordBits-1:0] wbData,
    output logic [cpuPkg::wordBits-1:0] outputPort,
    output logic                        wwdStrobe,
    output logic [cpuPkg::wordBits-1:0] numInst,
    output logic                        halted
);
    import cpuPkg::*;

    logic [wordBits-1:0] wbLoad;
    logic [wordBits-1:0] wbResult;
    logic                wbMemToReg;
    logic                wbRetire;

    assign dataAddress = memAddr;
    assign readM       = memMemRead;
    assign writeM      = memMemWrite;
    assign writeData   = memStoreData;

    // MEM/WB control and the output side
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbRegWrite <= 1'b0;
            wbMemToReg <= 1'b0;
            wbRetire   <= 1'b0;
            wwdStrobe  <= 1'b0;
            outputPort <= '0;
            halted     <= 1'b0;
            numInst    <= '0;
        end else begin
            wbRegWrite <= memRegWrite;
            wbMemToReg <= memMemToReg;
            wbRetire   <= memRetire;
            wwdStrobe  <= memIsWwd && memRetire;
            if (memIsWwd && memRetire) begin
                outputPort <= memResult;
            end
            if (memIsHalt && memRetire) begin
                halted <= 1'b1; // sticky until reset
            end
            if (wbRetire) begin
                numInst <= numInst + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wbRd     <= memRd;
        wbLoad   <= readData;
        wbResult <= memResult;
    end

    assign wbData = wbMemToReg ? wbLoad : wbResult;

    // nothing younger than HLT reaches WB
    assert property (@(posedge clk) disable iff (!rstN) !(wwdStrobe && halted));

endmodule

// File: source/pipelineCpu.sv
`timescale 1ns/1ps

module pipelineCpu (
    input  logic                        clk,
    input  logic                        rstN,
    output logic [cpuPkg::wordBits-1:0] instAddress,
    input  logic [cpuPkg::wordBits-1:0] instData,
    output logic [cpuPkg::wordBits-1:0] dataAddress,
    output logic                        readM,
    output logic                        writeM,
    output logic [cpuPkg::wordBits-1:0] writeData,
    input  logic [cpuPkg::wordBits-1:0] readData,
    output logic [cpuPkg::wordBits-1:0] outputPort,
    output logic                        wwdStrobe,
    output logic [cpuPkg::wordBits-1:0] numInst,
    output logic                        halted
);
    import cpuPkg::*;

    // fetch and decode
    logic                stall;
    logic                haltSeen;
    logic                redirect;
    logic [wordBits-1:0] redirectPc;
    logic [wordBits-1:0] ifPc;
    instrWord            ifInstr;
    logic                ifRetire;

    // ID/EX
    logic [wordBits-1:0] exPc;
    logic [wordBits-1:0] exA;
    logic [wordBits-1:0] exB;
    logic [wordBits-1:0] exImm;
    regAddr              exRs;
    regAddr              exRt;
    regAddr              exRd;
    aluOp                exAluOp;
    logic                exAluSrcImm;
    logic                exMemRead;
    logic                exMemWrite;
    logic                exRegWrite;
    logic                exMemToReg;
    logic                exIsWwd;
    logic                exIsHalt;
    logic [2:0]          exBranchKind;
    logic                exRetire;

    // EX/MEM
    logic [wordBits-1:0] memAddr;
    logic [wordBits-1:0] memStoreData;
    regAddr              memRd;
    logic                memRegWrite;
    logic                memMemRead;
    logic                memMemWrite;
    logic                memMemToReg;
    logic                memIsWwd;
    logic                memIsHalt;
    logic                memRetire;
    logic [wordBits-1:0] memResult;

    // writeback, also the forwarding source
    regAddr              wbRd;
    logic                wbRegWrite;
    logic [wordBits-1:0] wbData;

    fetchStage fetchStage_i (.*);

    decodeStage decodeStage_i (.*);

    executeStage executeStage_i (.*);

    memWriteback memWriteback_i (.*);

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                        clk,
    input  logic                        rstN,
    input  cpuPkg::regAddr              rsAddr,
    input  cpuPkg::regAddr              rtAddr,
    input  cpuPkg::regAddr              wAddr,
    input  logic [cpuPkg::wordBits-1:0] wData,
    input  logic                        wEn,
    output logic [cpuPkg::wordBits-1:0] rsData,
    output logic [cpuPkg::wordBits-1:0] rtData
);
    import cpuPkg::*;

    logic [wordBits-1:0] regs [4];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wEn) begin
            regs[wAddr] <= wData;
        end
    end

    // write-through covers the writeback to decode distance
    assign rsData = (wEn && wAddr == rsAddr) ? wData : regs[rsAddr];
    assign rtData = (wEn && wAddr == rtAddr) ? wData : regs[rtAddr];

endmodule

// File: src.f
source/cpuPkg.sv
source/fetchStage.sv
source/registerFile.sv
source/decodeStage.sv
source/executeStage.sv
source/memWriteback.sv
source/pipelineCpu.sv
tests/cpuTb.sv

// File: tests/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    localparam int resetCycles  = 10;
    localparam int haltTimeout  = 1000;
    localparam int settleCycles = 12;
    localparam logic [wordBits-1:0] markerValue = 16'hBAD0;
    // executed path of program.hex: 0..28, 31..34, 37, 41..42, 38, 44
    localparam int pathLength = 29 + 4 + 1 + 2 + 1 + 1;

    localparam int resetTest = 0;
    localparam int aluTest   = 1;
    localparam int memTest   = 2;
    localparam int flowTest  = 3;
    localparam int haltTest  = 4;

    logic                clk;
    logic                rstN;
    logic [wordBits-1:0] instAddress;
    logic [wordBits-1:0] instData;
    logic [wordBits-1:0] dataAddress;
    logic                readM;
    logic                writeM;
    logic [wordBits-1:0] writeData;
    logic [wordBits-1:0] readData;
    logic [wordBits-1:0] outputPort;
    logic                wwdStrobe;
    logic [wordBits-1:0] numInst;
    logic                halted;

    logic [wordBits-1:0] imem [0:63];
    logic [wordBits-1:0] dmem [0:255];
    logic [wordBits-1:0] dmemInit [0:255]; // untouched copy of the random fill
    integer              seed;

    logic [wordBits-1:0] wwdExpected [$];
    int                  wwdOwner [$];
    logic [wordBits-1:0] storeAddrExpected [$];
    logic [wordBits-1:0] storeDataExpected [$];

    string               testNames [5];
    int                  checkCount [5];
    int                  errorCount [5];

    pipelineCpu pipelineCpu_i (
        .clk         (clk),
        .rstN        (rstN),
        .instAddress (instAddress),
        .instData    (instData),
        .dataAddress (dataAddress),
        .readM       (readM),
        .writeM      (writeM),
        .writeData   (writeData),
        .readData    (readData),
        .outputPort  (outputPort),
        .wwdStrobe   (wwdStrobe),
        .numInst     (numInst),
        .halted      (halted)
    );

    always #10 clk = ~clk;

    // both memories answer within the cycle
    assign instData = imem[instAddress[5:0]];
    assign readData = dmem[dataAddress[7:0]];

    task automatic compareValue(input int test, input logic [wordBits-1:0] expected,
                                input logic [wordBits-1:0] actual);
        checkCount[test]++;
        if (actual !== expected) begin
            errorCount[test]++;
            $display("CHECK FAILED %s expected %h actual %h", testNames[test], expected, actual);
        end
    endtask

    task automatic reportProblem(input int test, input string what);
        checkCount[test]++;
        errorCount[test]++;
        $display("%s went wrong: %s", testNames[test], what);
    endtask

    task automatic queueOutput(input int test, input logic [wordBits-1:0] value);
        wwdExpected.push_back(value);
        wwdOwner.push_back(test);
    endtask

    task automatic recordStore(input logic [wordBits-1:0] addr, input logic [wordBits-1:0] data);
        storeAddrExpected.push_back(addr);
        storeDataExpected.push_back(data);
    endtask

    // register model walked along the program by hand
    task automatic buildExpected();
        logic [wordBits-1:0] r [4];
        logic [wordBits-1:0] addr;
        r[0] = '0;
        r[1] = 16'd5;
        r[2] = r[1] + 16'hFFFD;
        r[3] = r[1] + r[2];
        queueOutput(aluTest, r[3]);
        r[3] = r[3] - r[1];
        queueOutput(aluTest, r[3]);
        r[1] = 16'h5A00 | 16'h00C3; // LHI then ORI, zero extended
        queueOutput(aluTest, r[1]);
        r[2] = ~r[1];
        r[3] = r[2] | r[1];
        r[0] = r[3] & r[2];
        queueOutput(aluTest, r[0]);
        r[1] = r[0] << 1;
        r[3] = $signed(r[1]) >>> 1;
        queueOutput(aluTest, r[3]);
        queueOutput(aluTest, r[1]);

        r[0] = '0;
        r[1] = r[0] + 16'h0020;
        recordStore(r[1] + 16'h0004, r[3]);
        r[2] = r[3]; // read back from the stored word
        queueOutput(memTest, r[2]);
        addr = r[1] + 16'h0010;
        r[3] = dmemInit[addr[7:0]] + 16'd1;
        queueOutput(memTest, r[3]);
        recordStore(r[0] + 16'h0040, r[3]);

        // BEQ taken, BNE falls through
        r[0] = r[0] + 16'h0011;
        queueOutput(flowTest, r[0]);
        r[2] = 16'd37 + 16'd1; // link of the JAL at 37
        queueOutput(flowTest, r[2]);
    endtask

    task automatic inspectResetState();
        compareValue(resetTest, '0, 16'(readM));
        compareValue(resetTest, '0, 16'(writeM));
        compareValue(resetTest, '0, 16'(wwdStrobe));
        compareValue(resetTest, '0, 16'(halted));
        compareValue(resetTest, '0, numInst);
        compareValue(resetTest, '0, instAddress);
    endtask

    task automatic summarizeTest(input int test);
        $display("test %s: %0d checks, %0d errors",
                 testNames[test], checkCount[test], errorCount[test]);
    endtask

    // data memory write plus output and store checks
    always @(negedge clk) begin
        if (rstN === 1'b1) begin
            if (wwdStrobe === 1'b1) begin
                if (halted === 1'b1) begin
                    reportProblem(haltTest, "output strobe seen after halt");
                end else if (outputPort == markerValue) begin
                    reportProblem(flowTest, "a skipped path wrote its marker to the output");
                end else if (wwdExpected.size() == 0) begin
                    reportProblem(flowTest, "more output strobes than the program has");
                end else begin
                    compareValue(wwdOwner[0], wwdExpected[0], outputPort);
                    void'(wwdExpected.pop_front());
                    void'(wwdOwner.pop_front());
                end
            end
            if (writeM === 1'b1) begin
                if (storeAddrExpected.size() == 0) begin
                    reportProblem(memTest, "store the program does not contain");
                end else begin
                    compareValue(memTest, storeAddrExpected[0], dataAddress);
                    compareValue(memTest, storeDataExpected[0], writeData);
                    void'(storeAddrExpected.pop_front());
                    void'(storeDataExpected.pop_front());
                end
                dmem[dataAddress[7:0]] = writeData;
            end
        end
    end

    initial begin
        int cycles;
        int haltDrops;
        int totalChecks;
        int totalErrors;
        clk  = 1'b0;
        rstN = 1'b0;
        testNames = '{"resetState", "aluForwarding", "loadStore", "controlFlow", "retireHalt"};
        for (int i = 0; i < 5; i++) begin
            checkCount[i] = 0;
            errorCount[i] = 0;
        end
        $readmemh("tests/program.hex", imem);
        seed = 30;
        for (int i = 0; i < 256; i++) begin
            dmem[i]     = 16'($random(seed));
            dmemInit[i] = dmem[i];
        end
        buildExpected();

        for (int i = 0; i < resetCycles; i++) begin
            @(negedge clk);
            inspectResetState();
        end
        rstN = 1'b1;
        #1;
        inspectResetState(); // released, no edge yet
        summarizeTest(resetTest);

        cycles = 0;
        while (halted !== 1'b1 && cycles < haltTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            reportProblem(haltTest, $sformatf("halted still low after %0d cycles", haltTimeout));
        end

        // drain, then the core must stay quiet
        haltDrops = 0;
        for (int i = 0; i < settleCycles; i++) begin
            @(negedge clk);
            if (halted !== 1'b1) begin
                haltDrops++;
            end
        end
        if (haltDrops != 0) begin
            reportProblem(haltTest, "halted was low after the core stopped");
        end
        compareValue(haltTest, 16'(pathLength), numInst);
        if (wwdExpected.size() != 0) begin
            reportProblem(wwdOwner[0],
                          $sformatf("%0d expected outputs never appeared", wwdExpected.size()));
        end
        if (storeAddrExpected.size() != 0) begin
            reportProblem(memTest, "an expected store never happened");
        end
        for (int i = 1; i < 5; i++) begin
            summarizeTest(i);
        end

        totalChecks = 0;
        totalErrors = 0;
        for (int i = 0; i < 5; i++) begin
            totalChecks += checkCount[i];
            totalErrors += errorCount[i];
        end
        $display("tests 5, checks %0d, errors %0d", totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: tests/program.hex
// one 16-bit instruction word per line, address 0 first
// after each word: its address and the instruction
4105 // 0  ADI r1, r0, 5
46FD // 1  ADI r2, r1, -3
F6C0 // 2  ADD r3, r1, r2
FC1C // 3  WWD r3
FDC1 // 4  SUB r3, r3, r1
FC1C // 5  WWD r3
615A // 6  LHI r1, 0x5A
55C3 // 7  ORI r1, r1, 0xC3
F41C // 8  WWD r1
F484 // 9  NOT r2, r1
F9C3 // 10 ORR r3, r2, r1
FE02 // 11 AND r0, r3, r2
F01C // 12 WWD r0
F046 // 13 SHL r1, r0
F4C7 // 14 SHR r3, r1
FC1C // 15 WWD r3
F41C // 16 WWD r1
6000 // 17 LHI r0, 0
4120 // 18 ADI r1, r0, 0x20
8704 // 19 SWD r3, r1, 4
7604 // 20 LWD r2, r1, 4
F81C // 21 WWD r2
7710 // 22 LWD r3, r1, 0x10
4F01 // 23 ADI r3, r3, 1
FC1C // 24 WWD r3
8340 // 25 SWD r3, r0, 0x40
61BA // 26 LHI r1, 0xBA
55D0 // 27 ORI r1, r1, 0xD0
1002 // 28 BEQ r0, r0, +2
F41C // 29 WWD r1 skipped
F41C // 30 WWD r1 skipped
0001 // 31 BNE r0, r0, +1
4011 // 32 ADI r0, r0, 0x11
F01C // 33 WWD r0
9025 // 34 JMP 37
F41C // 35 WWD r1 skipped
F41C // 36 WWD r1 skipped
A029 // 37 JAL 41
902C // 38 JMP 44
F41C // 39 WWD r1 skipped
F41C // 40 WWD r1 skipped
F81C // 41 WWD r2
F819 // 42 JPR r2
F41C // 43 WWD r1 skipped
F01D // 44 HLT
F41C // 45 WWD r1 fetched after HLT
